// ==== rtl/tlb_pkg.sv ====
// shared widths, channel structs and page table entry layout; imported by every RTL module
package tlb_pkg;

	localparam int ADDR_W = 32;
	localparam int PAGE_BITS = 12;
	localparam int VPN_W = ADDR_W - PAGE_BITS;
	localparam int ID_W = 4;
	localparam int LEN_W = 8;
	localparam int PTE_W = 64;
	localparam int PTES_PER_LINE = 4;
	localparam int LINE_W = PTE_W * PTES_PER_LINE;

	localparam logic [1:0] RESP_OKAY = 2'd0;
	localparam logic [1:0] RESP_SLVERR = 2'd2;

	// one page table entry, tag in the top bits
	typedef struct packed {
		logic [VPN_W-1:0] tag;
		logic [VPN_W-1:0] ppn;
		logic [PTE_W-2*VPN_W-3:0] rsvd;
		logic readable;
		logic present;
	} pte_t;

	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0] len;
	} ar_t;

	// physical side carries one extra id bit for return routing
	typedef struct packed {
		logic [ID_W:0] id;
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0] len;
	} phys_ar_t;

	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [LINE_W-1:0] data;
		logic [1:0] resp;
		logic last;
	} r_t;

	typedef struct packed {
		logic [ID_W:0] id;
		logic [LINE_W-1:0] data;
		logic [1:0] resp;
		logic last;
	} phys_r_t;

	typedef struct packed {
		logic [VPN_W-1:0] vpn;
	} tlb_req_t;

	typedef struct packed {
		logic [VPN_W-1:0] ppn;
		logic ok;
	} tlb_resp_t;

endpackage

// ==== rtl/sync_fifo.sv ====
// first-word-fall-through FIFO with a type parameter for the payload, used for all buffering
`timescale 1ns/100ps

module sync_fifo import tlb_pkg::*; #(
	parameter type payload_t = tlb_req_t,
	parameter int DEPTH = 8
) (
	input logic clk,
	input logic rst,
	input payload_t wr_data,
	input logic wr_valid,
	output logic wr_ready,
	output payload_t rd_data,
	output logic rd_valid,
	input logic rd_ready
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic wr_fire;
	logic rd_fire;

	assign wr_ready = (count != CNT_W'(DEPTH));
	assign rd_valid = (count != '0);
	// head entry is visible without a read strobe
	assign rd_data = mem[rd_ptr];
	assign wr_fire = wr_valid && wr_ready;
	assign rd_fire = rd_valid && rd_ready;

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_fire) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_fire) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (wr_fire && !rd_fire) begin
				count <= count + 1'b1;
			end else if (rd_fire && !wr_fire) begin
				count <= count - 1'b1;
			end
		end
	end

	// empty and full both leave the pointers level
	a_ptrs_level: assert property (@(posedge clk) disable iff (rst)
		(count == '0 || count == CNT_W'(DEPTH)) |-> (wr_ptr == rd_ptr));
	a_ptrs_apart: assert property (@(posedge clk) disable iff (rst)
		(count != '0 && count != CNT_W'(DEPTH)) |-> (wr_ptr != rd_ptr));

endmodule

// ==== rtl/read_translator.sv ====
// read channel manager: takes virtual reads, requests translations, forwards or faults bursts
`timescale 1ns/100ps

module read_translator import tlb_pkg::*; #(
	parameter int FIFO_DEPTH = 8
) (
	input logic clk,
	input logic rst,
	input ar_t virt_ar,
	input logic virt_ar_valid,
	output logic virt_ar_ready,
	output r_t virt_r,
	output logic virt_r_valid,
	input logic virt_r_ready,
	output tlb_req_t tlb_req,
	output logic req_valid,
	input logic req_ready,
	input tlb_resp_t tlb_resp,
	input logic resp_valid,
	output phys_ar_t phys_ar,
	output logic phys_ar_valid,
	input logic phys_ar_ready,
	input phys_r_t phys_r,
	input logic phys_r_valid,
	output logic phys_r_ready
);

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [LEN_W-1:0] len;
		logic ok;
	} order_t;

	logic [CNT_W-1:0] credits;
	logic credit_ok;
	logic take_credit;
	ar_t meta_head;
	logic meta_wr_ready;
	logic meta_valid;
	tlb_resp_t res_head;
	logic res_valid;
	order_t ord_rec;
	order_t ord_head;
	logic ord_wr_ready;
	logic ord_valid;
	logic issue;
	phys_r_t beat_head;
	logic beat_valid;
	logic [LEN_W-1:0] beat_cnt;

	// request side only opens while a credit is free
	assign credit_ok = (credits < CNT_W'(FIFO_DEPTH));
	assign req_valid = virt_ar_valid && credit_ok && meta_wr_ready;
	assign virt_ar_ready = credit_ok && meta_wr_ready && req_ready;
	assign take_credit = virt_ar_valid && virt_ar_ready;
	assign tlb_req.vpn = virt_ar.addr[ADDR_W-1:PAGE_BITS];

	sync_fifo #(.payload_t(ar_t), .DEPTH(FIFO_DEPTH)) u_meta_fifo (
		.clk, .rst,
		.wr_data(virt_ar), .wr_valid(virt_ar_valid && credit_ok && req_ready),
		.wr_ready(meta_wr_ready),
		.rd_data(meta_head), .rd_valid(meta_valid), .rd_ready(issue)
	);

	// credits bound the results, so this FIFO never sees a write while full
	sync_fifo #(.payload_t(tlb_resp_t), .DEPTH(FIFO_DEPTH)) u_result_fifo (
		.clk, .rst,
		.wr_data(tlb_resp), .wr_valid(resp_valid), .wr_ready(),
		.rd_data(res_head), .rd_valid(res_valid), .rd_ready(issue)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= '0;
		end else if (take_credit && !issue) begin
			credits <= credits + 1'b1;
		end else if (issue && !take_credit) begin
			credits <= credits - 1'b1;
		end
	end

	// swap the page number, keep the offset
	assign phys_ar.id = {1'b0, meta_head.id};
	assign phys_ar.addr = {res_head.ppn, meta_head.addr[PAGE_BITS-1:0]};
	assign phys_ar.len = meta_head.len;
	assign phys_ar_valid = meta_valid && res_valid && res_head.ok && ord_wr_ready;
	assign issue = meta_valid && res_valid && ord_wr_ready && (!res_head.ok || phys_ar_ready);

	assign ord_rec.id = meta_head.id;
	assign ord_rec.len = meta_head.len;
	assign ord_rec.ok = res_head.ok;

	sync_fifo #(.payload_t(order_t), .DEPTH(FIFO_DEPTH)) u_order_fifo (
		.clk, .rst,
		.wr_data(ord_rec), .wr_valid(issue), .wr_ready(ord_wr_ready),
		.rd_data(ord_head), .rd_valid(ord_valid),
		.rd_ready(virt_r_valid && virt_r_ready && virt_r.last)
	);

	sync_fifo #(.payload_t(phys_r_t), .DEPTH(FIFO_DEPTH)) u_beat_fifo (
		.clk, .rst,
		.wr_data(phys_r), .wr_valid(phys_r_valid), .wr_ready(phys_r_ready),
		.rd_data(beat_head), .rd_valid(beat_valid),
		.rd_ready(virt_r_ready && ord_valid && ord_head.ok)
	);

	// faulted bursts are counted out locally
	assign virt_r_valid = ord_valid && (!ord_head.ok || beat_valid);
	assign virt_r.id = ord_head.id;
	assign virt_r.data = ord_head.ok ? beat_head.data : '0;
	assign virt_r.resp = ord_head.ok ? beat_head.resp : RESP_SLVERR;
	assign virt_r.last = ord_head.ok ? beat_head.last : (beat_cnt == ord_head.len);

	always_ff @(posedge clk) begin
		if (rst) begin
			beat_cnt <= '0;
		end else if (virt_r_valid && virt_r_ready) begin
			beat_cnt <= virt_r.last ? '0 : beat_cnt + 1'b1;
		end
	end

	// the walker may only answer a request this side has paid for
	a_resp_has_credit: assert property (@(posedge clk) disable iff (rst)
		resp_valid |-> (credits != '0));

endmodule

// ==== rtl/page_walker.sv ====
// page walker: fetches page table lines and answers translations from a parallel entry compare
`timescale 1ns/100ps

module page_walker import tlb_pkg::*; #(
	parameter int FIFO_DEPTH = 8,
	parameter logic [ADDR_W-1:0] PT_BASE = 32'h0010_0000,
	parameter int SET_BITS = 6
) (
	input logic clk,
	input logic rst,
	input tlb_req_t tlb_req,
	input logic req_valid,
	output logic req_ready,
	output tlb_resp_t tlb_resp,
	output logic resp_valid,
	output phys_ar_t walk_ar,
	output logic walk_ar_valid,
	input logic walk_ar_ready,
	input phys_r_t walk_r,
	input logic walk_r_valid,
	output logic walk_r_ready
);

	localparam int LINE_SHIFT = $clog2(LINE_W / 8);

	logic vq_wr_ready;
	tlb_req_t vpn_head;
	logic vq_valid;
	logic [PTES_PER_LINE-1:0] hit;
	logic [PTES_PER_LINE-1:0] hit_rd;
	logic [VPN_W-1:0] ppn_part [PTES_PER_LINE];
	logic [VPN_W-1:0] ppn_or;

	// one line fetch per request, set picked by the low vpn bits
	assign walk_ar.id = '0;
	assign walk_ar.addr = PT_BASE + (ADDR_W'(tlb_req.vpn[SET_BITS-1:0]) << LINE_SHIFT);
	assign walk_ar.len = '0;
	assign walk_ar_valid = req_valid && vq_wr_ready;
	assign req_ready = walk_ar_ready && vq_wr_ready;

	// lines come back in order, so the queue head names the line
	sync_fifo #(.payload_t(tlb_req_t), .DEPTH(FIFO_DEPTH)) u_vpn_fifo (
		.clk, .rst,
		.wr_data(tlb_req), .wr_valid(req_valid && walk_ar_ready), .wr_ready(vq_wr_ready),
		.rd_data(vpn_head), .rd_valid(vq_valid), .rd_ready(walk_r_valid)
	);

	assign walk_r_ready = 1'b1;

	for (genvar g = 0; g < PTES_PER_LINE; g++) begin : g_pte
		pte_t pte;

		assign pte = walk_r.data[g*PTE_W +: PTE_W];
		assign hit[g] = pte.present && (pte.tag == vpn_head.vpn);
		assign hit_rd[g] = hit[g] && pte.readable;
		assign ppn_part[g] = hit[g] ? pte.ppn : '0;
	end

	// multiple hits merge by OR
	always_comb begin
		ppn_or = '0;
		for (int i = 0; i < PTES_PER_LINE; i++) begin
			ppn_or = ppn_or | ppn_part[i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= walk_r_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (walk_r_valid) begin
			tlb_resp.ppn <= ppn_or;
			tlb_resp.ok <= (|hit) && (|hit_rd);
		end
	end

	a_line_has_vpn: assert property (@(posedge clk) disable iff (rst)
		walk_r_valid |-> vq_valid);

endmodule

// ==== rtl/phys_read_mux.sv ====
// shares the physical read port between walker and translator, routing returns by id bit 0
`timescale 1ns/100ps

module phys_read_mux import tlb_pkg::*; (
	input phys_ar_t walk_ar,
	input logic walk_ar_valid,
	output logic walk_ar_ready,
	output phys_r_t walk_r,
	output logic walk_r_valid,
	input logic walk_r_ready,
	input phys_ar_t xlat_ar,
	input logic xlat_ar_valid,
	output logic xlat_ar_ready,
	output phys_r_t xlat_r,
	output logic xlat_r_valid,
	input logic xlat_r_ready,
	output phys_ar_t phys_ar,
	output logic phys_ar_valid,
	input logic phys_ar_ready,
	input phys_r_t phys_r,
	input logic phys_r_valid,
	output logic phys_r_ready
);

	phys_r_t ret;
	logic to_xlat;

	// walker wins the address channel
	always_comb begin
		if (walk_ar_valid) begin
			phys_ar = walk_ar;
			phys_ar.id = {walk_ar.id[ID_W-1:0], 1'b0};
		end else begin
			phys_ar = xlat_ar;
			phys_ar.id = {xlat_ar.id[ID_W-1:0], 1'b1};
		end
	end

	assign phys_ar_valid = walk_ar_valid || xlat_ar_valid;
	assign walk_ar_ready = phys_ar_ready;
	assign xlat_ar_ready = phys_ar_ready && !walk_ar_valid;

	// strip the source tag on the way back
	always_comb begin
		ret = phys_r;
		ret.id = {1'b0, phys_r.id[ID_W:1]};
	end

	assign to_xlat = phys_r.id[0];
	assign walk_r = ret;
	assign xlat_r = ret;
	assign walk_r_valid = phys_r_valid && !to_xlat;
	assign xlat_r_valid = phys_r_valid && to_xlat;
	assign phys_r_ready = to_xlat ? xlat_r_ready : walk_r_ready;

endmodule

// ==== rtl/axi_read_tlb.sv ====
// read-only address translator top; virtual read port in, physical read port out
`timescale 1ns/100ps

module axi_read_tlb import tlb_pkg::*; #(
	parameter int FIFO_DEPTH = 8,
	parameter logic [ADDR_W-1:0] PT_BASE = 32'h0010_0000,
	parameter int SET_BITS = 6
) (
	input logic clk,
	input logic rst,
	input ar_t virt_ar,
	input logic virt_ar_valid,
	output logic virt_ar_ready,
	output r_t virt_r,
	output logic virt_r_valid,
	input logic virt_r_ready,
	output phys_ar_t phys_ar,
	output logic phys_ar_valid,
	input logic phys_ar_ready,
	input phys_r_t phys_r,
	input logic phys_r_valid,
	output logic phys_r_ready
);

	tlb_req_t tlb_req;
	logic req_valid;
	logic req_ready;
	tlb_resp_t tlb_resp;
	logic resp_valid;
	phys_ar_t walk_ar;
	logic walk_ar_valid;
	logic walk_ar_ready;
	phys_r_t walk_r;
	logic walk_r_valid;
	logic walk_r_ready;
	phys_ar_t xlat_ar;
	logic xlat_ar_valid;
	logic xlat_ar_ready;
	phys_r_t xlat_r;
	logic xlat_r_valid;
	logic xlat_r_ready;

	read_translator #(.FIFO_DEPTH(FIFO_DEPTH)) u_read_translator (
		.phys_ar(xlat_ar), .phys_ar_valid(xlat_ar_valid), .phys_ar_ready(xlat_ar_ready),
		.phys_r(xlat_r), .phys_r_valid(xlat_r_valid), .phys_r_ready(xlat_r_ready),
		.*
	);

	page_walker #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.PT_BASE(PT_BASE),
		.SET_BITS(SET_BITS)
	) u_page_walker (.*);

	phys_read_mux u_phys_read_mux (.*);

endmodule

// ==== dv/tb_clk_gen.sv ====
// clock and reset source for the testbench; reset is held for a fixed number of cycles
`timescale 1ns/100ps

module tb_clk_gen #(
	parameter int PERIOD = 10,
	parameter int RST_CYCLES = 8
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== dv/tb_phys_mem.sv ====
// physical memory model for the testbench; serves page table lines and patterned data in order
`timescale 1ns/100ps

module tb_phys_mem import tlb_pkg::*; #(
	parameter logic [ADDR_W-1:0] PT_BASE = 32'h0010_0000,
	parameter int SET_BITS = 6,
	parameter int SEED = 1
) (
	input logic clk,
	input logic rst,
	input phys_ar_t phys_ar,
	input logic phys_ar_valid,
	output logic phys_ar_ready,
	output phys_r_t phys_r,
	output logic phys_r_valid,
	input logic phys_r_ready
);

	localparam int NUM_SETS = 1 << SET_BITS;
	localparam int LINE_BYTES = LINE_W / 8;

	// loaded by the testbench top before reset ends
	logic [LINE_W-1:0] pt_lines [NUM_SETS];
	phys_ar_t pending [$];
	int beat;
	integer seed;

	function automatic phys_r_t read_beat(input phys_ar_t ar, input int n);
		phys_r_t r;
		r.id = ar.id;
		r.resp = RESP_OKAY;
		r.last = (n == int'(ar.len));
		if (ar.addr >= PT_BASE && ar.addr < PT_BASE + ADDR_W'(NUM_SETS * LINE_BYTES)) begin
			r.data = pt_lines[(ar.addr - PT_BASE) / LINE_BYTES];
		end else begin
			// beat address replicated across the line
			r.data = {(LINE_W / 32){ar.addr + ADDR_W'(n * LINE_BYTES)}};
		end
		return r;
	endfunction

	initial begin : serve
		seed = SEED;
		phys_ar_ready = 1'b0;
		phys_r = '0;
		phys_r_valid = 1'b0;
		beat = 0;
		forever begin
			@(posedge clk);
			if (rst) begin
				pending.delete();
				beat = 0;
				phys_ar_ready <= 1'b0;
				phys_r_valid <= 1'b0;
			end else begin
				if (phys_r_valid && phys_r_ready) begin
					if (phys_r.last) begin
						void'(pending.pop_front());
						beat = 0;
					end else begin
						beat++;
					end
				end
				if (phys_ar_valid && phys_ar_ready) begin
					pending.push_back(phys_ar);
				end
				// refuse about a quarter of the address cycles
				phys_ar_ready <= (($random(seed) & 3) != 0);
				phys_r_valid <= (pending.size() != 0);
				if (pending.size() != 0) begin
					phys_r <= read_beat(pending[0], beat);
				end
			end
		end
	end

endmodule

// ==== dv/tb_axi_read_tlb.sv ====
// testbench top; issues virtual reads and checks every returned beat against a reference model
`timescale 1ns/100ps

module tb_axi_read_tlb import tlb_pkg::*; ();

	localparam int FIFO_DEPTH = 8;
	localparam logic [ADDR_W-1:0] PT_BASE = 32'h0010_0000;
	localparam int SET_BITS = 6;
	localparam int NUM_SETS = 1 << SET_BITS;
	localparam int TIMEOUT = 2000;
	localparam int MIX_READS = 20;

	// set = low six vpn bits
	localparam logic [VPN_W-1:0] VPN_MAPPED = 20'h00041;
	localparam logic [VPN_W-1:0] VPN_NOREAD = 20'h00082;
	localparam logic [VPN_W-1:0] VPN_SHARED = 20'h000c2;
	localparam logic [VPN_W-1:0] VPN_ABSENT = 20'h00103;
	localparam logic [VPN_W-1:0] VPN_NEIGHBOR = 20'h00143;
	localparam logic [VPN_W-1:0] VPN_BURST_A = 20'h00204;
	localparam logic [VPN_W-1:0] VPN_BURST_B = 20'h00305;
	localparam logic [VPN_W-1:0] VPN_EMPTY = 20'h00a07;

	logic clk;
	logic rst;
	ar_t virt_ar;
	logic virt_ar_valid;
	logic virt_ar_ready;
	r_t virt_r;
	logic virt_r_valid;
	logic virt_r_ready;
	phys_ar_t phys_ar;
	logic phys_ar_valid;
	logic phys_ar_ready;
	phys_r_t phys_r;
	logic phys_r_valid;
	logic phys_r_ready;

	integer seed = 32'h666026e6;
	string test_name = "reset";
	logic bp_on = 1'b0;
	ar_t issued [$];
	int beat_idx;
	int bursts_done = 0;

	tb_clk_gen #(.PERIOD(10), .RST_CYCLES(8)) u_clk_gen (.clk, .rst);

	axi_read_tlb #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.PT_BASE(PT_BASE),
		.SET_BITS(SET_BITS)
	) u_axi_read_tlb (.*);

	tb_phys_mem #(.PT_BASE(PT_BASE), .SET_BITS(SET_BITS), .SEED(32'h666026e6)) u_phys_mem (.*);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic set_pte(input logic [VPN_W-1:0] tag, input int slot,
			input logic [VPN_W-1:0] ppn, input logic readable, input logic present);
		pte_t pte;
		pte = '{tag: tag, ppn: ppn, rsvd: '0, readable: readable, present: present};
		u_phys_mem.pt_lines[int'(tag) % NUM_SETS][slot*PTE_W +: PTE_W] = pte;
	endtask

	function automatic ar_t build_read(input logic [ID_W-1:0] id, input logic [VPN_W-1:0] vpn,
			input logic [PAGE_BITS-1:0] offset, input logic [LEN_W-1:0] len);
		ar_t req;
		req = '{id: id, addr: {vpn, offset}, len: len};
		return req;
	endfunction

	// expected beat from the table contents
	function automatic r_t expected_beat(input ar_t req, input int beat);
		r_t want;
		pte_t pte;
		logic [VPN_W-1:0] vpn;
		logic [VPN_W-1:0] ppn;
		logic [ADDR_W-1:0] base;
		logic found;
		logic readable;
		vpn = req.addr[ADDR_W-1:PAGE_BITS];
		ppn = '0;
		found = 1'b0;
		readable = 1'b0;
		for (int i = 0; i < PTES_PER_LINE; i++) begin
			pte = u_phys_mem.pt_lines[int'(vpn) % NUM_SETS][i*PTE_W +: PTE_W];
			if (pte.present && pte.tag == vpn) begin
				found = 1'b1;
				readable = readable | pte.readable;
				ppn = ppn | pte.ppn;
			end
		end
		base = {ppn, req.addr[PAGE_BITS-1:0]};
		want.id = req.id;
		want.last = (beat == int'(req.len));
		if (found && readable) begin
			want.data = {(LINE_W / 32){base + ADDR_W'(beat * 32)}};
			want.resp = RESP_OKAY;
		end else begin
			want.data = '0;
			want.resp = RESP_SLVERR;
		end
		return want;
	endfunction

	task automatic issue_read(input ar_t req);
		int waited;
		waited = 0;
		virt_ar <= req;
		virt_ar_valid <= 1'b1;
		@(posedge clk);
		while (!virt_ar_ready) begin
			if (waited == TIMEOUT) begin
				report_failure($sformatf("read address was never accepted in %s", test_name));
			end else begin
				waited++;
				@(posedge clk);
			end
		end
		issued.push_back(req);
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		virt_ar_valid <= 1'b0;
		while (issued.size() != 0) begin
			if (waited == TIMEOUT * 5) begin
				report_failure($sformatf("outstanding reads never completed in %s", test_name));
			end else begin
				waited++;
				@(posedge clk);
			end
		end
	endtask

	initial begin : compare
		r_t want;
		virt_r_ready = 1'b0;
		beat_idx = 0;
		forever begin
			@(posedge clk);
			if (!rst && virt_r_valid && virt_r_ready) begin
				assert (issued.size() != 0)
				else report_failure("a read data beat arrived with no read outstanding");
				want = expected_beat(issued[0], beat_idx);
				assert (virt_r == want)
				else report_failure($sformatf("** Error %s: burst %0d beat %0d expected %h actual %h",
					test_name, bursts_done, beat_idx, want, virt_r));
				if (want.last) begin
					void'(issued.pop_front());
					beat_idx = 0;
					bursts_done++;
				end else begin
					beat_idx++;
				end
			end
			virt_r_ready <= bp_on ? (($random(seed) & 3) != 0) : 1'b1;
		end
	end

	initial begin : stimulus
		ar_t mix [$];
		logic [VPN_W-1:0] pool [8];
		int pick;
		int rand_id;
		int rand_off;
		int rand_len;
		int waited;
		virt_ar = '0;
		virt_ar_valid = 1'b0;
		for (int s = 0; s < NUM_SETS; s++) begin
			u_phys_mem.pt_lines[s] = '0;
		end
		set_pte(VPN_MAPPED, 0, 20'h12345, 1'b1, 1'b1);
		set_pte(VPN_NOREAD, 1, 20'h22222, 1'b0, 1'b1);
		set_pte(VPN_SHARED, 3, 20'h33333, 1'b1, 1'b1);
		set_pte(VPN_NEIGHBOR, 0, 20'h44444, 1'b1, 1'b1);
		// right tag but not present
		set_pte(VPN_ABSENT, 2, 20'h4f4f4, 1'b1, 1'b0);
		set_pte(VPN_BURST_A, 2, 20'h55555, 1'b1, 1'b1);
		set_pte(VPN_BURST_B, 3, 20'h66666, 1'b1, 1'b1);
		pool = '{VPN_MAPPED, VPN_NOREAD, VPN_SHARED, VPN_ABSENT,
			VPN_NEIGHBOR, VPN_BURST_A, VPN_BURST_B, VPN_EMPTY};
		for (int n = 0; n < MIX_READS; n++) begin
			rand_id = $random(seed);
			pick = $random(seed) & 7;
			rand_off = $random(seed);
			rand_len = $random(seed) & 7;
			mix.push_back(build_read(ID_W'(rand_id), pool[pick], PAGE_BITS'(rand_off),
				LEN_W'(rand_len)));
		end

		waited = 0;
		@(posedge clk);
		while (rst) begin
			if (waited == 100) begin
				report_failure("reset was never released");
			end else begin
				waited++;
				@(posedge clk);
			end
		end

		test_name = "mapped_single";
		issue_read(build_read(4'h3, VPN_MAPPED, 12'h0a4, 8'd0));
		wait_drained();
		test_name = "absent_fault";
		issue_read(build_read(4'h5, VPN_ABSENT, 12'h010, 8'd3));
		wait_drained();
		test_name = "unreadable_fault";
		issue_read(build_read(4'h6, VPN_NOREAD, 12'h200, 8'd1));
		issue_read(build_read(4'h7, VPN_SHARED, 12'h040, 8'd0));
		wait_drained();
		test_name = "burst_backpressure";
		bp_on <= 1'b1;
		issue_read(build_read(4'h1, VPN_BURST_A, 12'h100, 8'd7));
		issue_read(build_read(4'h2, VPN_BURST_B, 12'h000, 8'd4));
		issue_read(build_read(4'h9, VPN_MAPPED, 12'h3c0, 8'd2));
		issue_read(build_read(4'ha, VPN_EMPTY, 12'h020, 8'd5));
		wait_drained();
		test_name = "random_mix";
		foreach (mix[n]) begin
			issue_read(mix[n]);
		end
		wait_drained();

		// one more edge so the last pop has settled
		@(posedge clk);
		if (!virt_r_valid) begin
			$display("Regression passed");
			$finish;
		end else begin
			report_failure($sformatf("a read data beat was left over after %0d bursts",
				bursts_done));
		end
	end

endmodule

// ==== filelist.f ====
rtl/tlb_pkg.sv
rtl/sync_fifo.sv
rtl/read_translator.sv
rtl/page_walker.sv
rtl/phys_read_mux.sv
rtl/axi_read_tlb.sv
dv/tb_clk_gen.sv
dv/tb_phys_mem.sv
dv/tb_axi_read_tlb.sv

// ==== Bender.yml ====
package:
  name: axi_read_tlb

sources:
  - rtl/tlb_pkg.sv
  - rtl/sync_fifo.sv
  - rtl/read_translator.sv
  - rtl/page_walker.sv
  - rtl/phys_read_mux.sv
  - rtl/axi_read_tlb.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_phys_mem.sv
      - dv/tb_axi_read_tlb.sv
